/* verilog/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int xlen        = 64;
    localparam int word_width  = 32;
    localparam int flush_depth = 2;                 // cycles squashed behind a taken jump

    typedef logic [4:0]                         reg_addr_t;
    typedef logic [xlen-1:0]                    xword_t;
    typedef logic [2:0]                         funct_t;
    typedef logic [3:0]                         ex_op_t;
    typedef logic [$clog2(flush_depth+1)-1:0]   flush_cnt_t;

    localparam ex_op_t op_reg      = 4'd0;
    localparam ex_op_t op_reg_alt  = 4'd1;          // sub, sra
    localparam ex_op_t op_imm      = 4'd2;
    localparam ex_op_t op_imm_sra  = 4'd3;
    localparam ex_op_t op_load     = 4'd4;
    localparam ex_op_t op_store    = 4'd5;
    localparam ex_op_t op_branch   = 4'd6;
    localparam ex_op_t op_jal      = 4'd7;
    localparam ex_op_t op_jalr     = 4'd8;
    localparam ex_op_t op_lui      = 4'd9;
    localparam ex_op_t op_auipc    = 4'd10;

    localparam funct_t fn_add  = 3'd0;
    localparam funct_t fn_sll  = 3'd1;
    localparam funct_t fn_slt  = 3'd2;
    localparam funct_t fn_sltu = 3'd3;
    localparam funct_t fn_xor  = 3'd4;
    localparam funct_t fn_srl  = 3'd5;
    localparam funct_t fn_or   = 3'd6;
    localparam funct_t fn_and  = 3'd7;

    localparam funct_t fn_beq  = 3'd0;
    localparam funct_t fn_bne  = 3'd1;
    localparam funct_t fn_blt  = 3'd4;
    localparam funct_t fn_bge  = 3'd5;
    localparam funct_t fn_bltu = 3'd6;
    localparam funct_t fn_bgeu = 3'd7;

    localparam xword_t link_offset = 64'd4;

    function automatic xword_t sext_word(input xword_t v);
        return {{(xlen - word_width){v[word_width-1]}}, v[word_width-1:0]};
    endfunction

endpackage

`default_nettype wire

/* verilog/opnd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface opnd_if;

    ex_pkg::xword_t  rs1;
    ex_pkg::xword_t  rs2;
    ex_pkg::xword_t  imm;
    ex_pkg::xword_t  pc;
    ex_pkg::ex_op_t  op;
    ex_pkg::funct_t  funct;
    logic            word;          // 32-bit word mode

    modport source (
        output rs1, rs2, imm, pc, op, funct, word
    );

    modport sink (
        input  rs1, rs2, imm, pc, op, funct, word
    );

endinterface

`default_nettype wire

/* verilog/exec_out_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface exec_out_if;

    ex_pkg::xword_t  alu_result;
    logic            take;          // branch or jump taken
    ex_pkg::xword_t  target;
    ex_pkg::xword_t  link;

    modport alu_source (
        output alu_result
    );

    modport branch_source (
        output take, target, link
    );

    modport sink (
        input  alu_result, take, target, link
    );

endinterface

`default_nettype wire

/* verilog/operand_forward.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
    input  ex_pkg::reg_addr_t  rs1_addr_i,
    input  ex_pkg::reg_addr_t  rs2_addr_i,
    input  ex_pkg::xword_t     rs1_data_i,
    input  ex_pkg::xword_t     rs2_data_i,
    input  ex_pkg::xword_t     imm_i,
    input  ex_pkg::xword_t     pc_i,
    input  ex_pkg::ex_op_t     op_i,
    input  ex_pkg::funct_t     funct_i,
    input  logic               word_i,
    input  logic               fwd_alu_en_i,
    input  ex_pkg::reg_addr_t  fwd_alu_addr_i,
    input  ex_pkg::xword_t     fwd_alu_data_i,
    input  logic               fwd_ld_en_i,
    input  ex_pkg::reg_addr_t  fwd_ld_addr_i,
    input  ex_pkg::xword_t     fwd_ld_data_i,
    input  logic               fwd_mem_en_i,
    input  ex_pkg::reg_addr_t  fwd_mem_addr_i,
    input  ex_pkg::xword_t     fwd_mem_data_i,
    input  logic               fwd_wb_en_i,
    input  ex_pkg::reg_addr_t  fwd_wb_addr_i,
    input  ex_pkg::xword_t     fwd_wb_data_i,
    opnd_if.source             opnd
);

    logic [3:0]         src_en;         // index 0 has the highest priority
    ex_pkg::reg_addr_t  src_addr [4];
    ex_pkg::xword_t     src_data [4];
    ex_pkg::xword_t     rs1_fwd;
    ex_pkg::xword_t     rs2_fwd;

    function automatic ex_pkg::xword_t pick(
        input ex_pkg::reg_addr_t  addr,
        input ex_pkg::xword_t     rf_data,
        input logic [3:0]         en,
        input ex_pkg::reg_addr_t  addrs [4],
        input ex_pkg::xword_t     datas [4]
    );
        ex_pkg::xword_t val;
        val = rf_data;
        for (int i = 3; i >= 0; i--) begin     // lowest index written last wins
            if (en[i] && (addrs[i] == addr)) begin
                val = datas[i];
            end
        end
        if (addr == '0) begin
            val = '0;                           // x0 always reads zero
        end
        return val;
    endfunction

    assign src_en   = {fwd_wb_en_i, fwd_mem_en_i, fwd_ld_en_i, fwd_alu_en_i};
    assign src_addr = '{fwd_alu_addr_i, fwd_ld_addr_i, fwd_mem_addr_i, fwd_wb_addr_i};
    assign src_data = '{fwd_alu_data_i, fwd_ld_data_i, fwd_mem_data_i, fwd_wb_data_i};

    assign rs1_fwd = pick(rs1_addr_i, rs1_data_i, src_en, src_addr, src_data);
    assign rs2_fwd = pick(rs2_addr_i, rs2_data_i, src_en, src_addr, src_data);

    assign opnd.rs1   = word_i ? ex_pkg::sext_word(rs1_fwd) : rs1_fwd;
    assign opnd.rs2   = word_i ? ex_pkg::sext_word(rs2_fwd) : rs2_fwd;
    assign opnd.imm   = word_i ? ex_pkg::sext_word(imm_i) : imm_i;
    assign opnd.pc    = pc_i;
    assign opnd.op    = op_i;
    assign opnd.funct = funct_i;
    assign opnd.word  = word_i;

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    opnd_if.sink            opnd,
    exec_out_if.alu_source  res
);

    logic            is_int;
    logic            use_rs2;
    logic            arith;
    logic            sub;
    logic            carry;
    logic            lt_s;
    logic            lt_u;
    logic            word_ext;
    logic [5:0]      shamt;
    ex_pkg::xword_t  op_a;
    ex_pkg::xword_t  op_b;
    ex_pkg::xword_t  sum;
    ex_pkg::xword_t  shl;
    ex_pkg::xword_t  shr_in;
    ex_pkg::xword_t  shr;
    ex_pkg::xword_t  raw;

    assign use_rs2 = (opnd.op == ex_pkg::op_reg) || (opnd.op == ex_pkg::op_reg_alt);
    assign is_int  = use_rs2 || (opnd.op == ex_pkg::op_imm) || (opnd.op == ex_pkg::op_imm_sra);
    assign arith   = (opnd.op == ex_pkg::op_reg_alt) || (opnd.op == ex_pkg::op_imm_sra);

    assign op_a = (opnd.op == ex_pkg::op_auipc) ? opnd.pc : opnd.rs1;
    assign op_b = use_rs2 ? opnd.rs2 : opnd.imm;

    // one adder for add, sub and both compares
    assign sub = is_int && (((opnd.op == ex_pkg::op_reg_alt) && (opnd.funct == ex_pkg::fn_add))
                 || (opnd.funct == ex_pkg::fn_slt) || (opnd.funct == ex_pkg::fn_sltu));
    assign {carry, sum} = {1'b0, op_a} + {1'b0, op_b ^ {ex_pkg::xlen{sub}}}
                          + (ex_pkg::xlen + 1)'(sub);
    assign lt_u = ~carry;                                       // no carry out means a < b
    assign lt_s = (op_a[ex_pkg::xlen-1] ^ op_b[ex_pkg::xlen-1]) ? op_a[ex_pkg::xlen-1]
                                                                : sum[ex_pkg::xlen-1];

    assign shamt  = opnd.word ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign shl    = op_a << shamt;
    assign shr_in = (opnd.word && !arith)
                  ? {{(ex_pkg::xlen - ex_pkg::word_width){1'b0}}, op_a[ex_pkg::word_width-1:0]}
                  : op_a;                                       // word sra relies on sext operand
    assign shr    = arith ? ex_pkg::xword_t'($signed(shr_in) >>> shamt) : (shr_in >> shamt);

    always_comb begin
        case (opnd.funct)
            ex_pkg::fn_add:  raw = sum;
            ex_pkg::fn_sll:  raw = shl;
            ex_pkg::fn_slt:  raw = {{(ex_pkg::xlen - 1){1'b0}}, lt_s};
            ex_pkg::fn_sltu: raw = {{(ex_pkg::xlen - 1){1'b0}}, lt_u};
            ex_pkg::fn_xor:  raw = op_a ^ op_b;
            ex_pkg::fn_srl:  raw = shr;
            ex_pkg::fn_or:   raw = op_a | op_b;
            default:         raw = op_a & op_b;
        endcase
    end

    assign word_ext = opnd.word && ((opnd.funct == ex_pkg::fn_add)
                      || (opnd.funct == ex_pkg::fn_sll) || (opnd.funct == ex_pkg::fn_srl));

    always_comb begin
        if (is_int) begin
            res.alu_result = word_ext ? ex_pkg::sext_word(raw) : raw;
        end else if (opnd.op == ex_pkg::op_lui) begin
            res.alu_result = opnd.imm;
        end else begin
            res.alu_result = sum;                               // load/store address, auipc
        end
    end

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    opnd_if.sink               opnd,
    exec_out_if.branch_source  res
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond;
    logic            is_jump;
    ex_pkg::xword_t  base;

    assign eq   = (opnd.rs1 == opnd.rs2);
    assign lt_s = ($signed(opnd.rs1) < $signed(opnd.rs2));
    assign lt_u = (opnd.rs1 < opnd.rs2);

    always_comb begin
        case (opnd.funct)
            ex_pkg::fn_beq:  cond = eq;
            ex_pkg::fn_bne:  cond = !eq;
            ex_pkg::fn_blt:  cond = lt_s;
            ex_pkg::fn_bge:  cond = !lt_s;
            ex_pkg::fn_bltu: cond = lt_u;
            ex_pkg::fn_bgeu: cond = !lt_u;
            default:         cond = 1'b0;       // unused funct codes never branch
        endcase
    end

    assign is_jump = (opnd.op == ex_pkg::op_jal) || (opnd.op == ex_pkg::op_jalr);

    assign res.take = is_jump || ((opnd.op == ex_pkg::op_branch) && cond);

    // jalr is register relative, everything else pc relative
    assign base       = (opnd.op == ex_pkg::op_jalr) ? opnd.rs1 : opnd.pc;
    assign res.target = base + opnd.imm;
    assign res.link   = opnd.pc + ex_pkg::link_offset;

endmodule

`default_nettype wire

/* verilog/ex_retire.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_retire (
    input  logic               clk_sys_i,
    input  logic               rst_sys_i,
    input  logic               valid_i,
    input  logic               stall_i,
    opnd_if.sink               opnd,
    exec_out_if.sink           res,
    input  ex_pkg::reg_addr_t  rd_i,
    output logic               valid_o,
    output logic               rd_we_o,
    output logic               jump_o,
    output ex_pkg::xword_t     jump_addr_o,
    output ex_pkg::xword_t     result_o,
    output ex_pkg::xword_t     store_data_o,
    output ex_pkg::reg_addr_t  rd_o,
    output ex_pkg::ex_op_t     op_o,
    output ex_pkg::funct_t     funct_o,
    output logic               ready_o
);

    ex_pkg::flush_cnt_t  flush_cnt;
    logic                accept;
    logic                is_jump;
    logic                we;

    assign ready_o = !stall_i && (flush_cnt == '0);
    assign accept  = valid_i && ready_o;
    assign is_jump = (opnd.op == ex_pkg::op_jal) || (opnd.op == ex_pkg::op_jalr);

    always_comb begin
        case (opnd.op)
            ex_pkg::op_reg, ex_pkg::op_reg_alt, ex_pkg::op_imm, ex_pkg::op_imm_sra,
            ex_pkg::op_lui, ex_pkg::op_auipc, ex_pkg::op_jal, ex_pkg::op_jalr: we = 1'b1;
            default: we = 1'b0;                 // load writes back later, store/branch never
        endcase
    end

    always_ff @(posedge clk_sys_i) begin
        if (rst_sys_i) begin
            valid_o   <= 1'b0;
            jump_o    <= 1'b0;
            rd_we_o   <= 1'b0;
            flush_cnt <= '0;
        end else if (!stall_i) begin            // stall freezes the whole stage
            valid_o <= accept;
            jump_o  <= accept && res.take;
            rd_we_o <= accept && we;
            if (accept && res.take) begin
                flush_cnt <= ex_pkg::flush_cnt_t'(ex_pkg::flush_depth);
            end else if (flush_cnt != '0) begin
                flush_cnt <= flush_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (accept) begin
            jump_addr_o  <= res.target;
            result_o     <= is_jump ? res.link : res.alu_result;
            store_data_o <= opnd.rs2;
            rd_o         <= rd_i;
            op_o         <= opnd.op;
            funct_o      <= opnd.funct;
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
    input  logic               clk_sys_i,
    input  logic               rst_sys_i,
    input  logic               valid_i,
    input  logic               stall_i,
    input  ex_pkg::reg_addr_t  rd_i,
    input  ex_pkg::reg_addr_t  rs1_addr_i,
    input  ex_pkg::reg_addr_t  rs2_addr_i,
    input  ex_pkg::xword_t     rs1_data_i,
    input  ex_pkg::xword_t     rs2_data_i,
    input  ex_pkg::xword_t     imm_i,
    input  ex_pkg::xword_t     pc_i,
    input  ex_pkg::ex_op_t     op_i,
    input  ex_pkg::funct_t     funct_i,
    input  logic               word_i,
    input  logic               fwd_alu_en_i,
    input  ex_pkg::reg_addr_t  fwd_alu_addr_i,
    input  ex_pkg::xword_t     fwd_alu_data_i,
    input  logic               fwd_ld_en_i,
    input  ex_pkg::reg_addr_t  fwd_ld_addr_i,
    input  ex_pkg::xword_t     fwd_ld_data_i,
    input  logic               fwd_mem_en_i,
    input  ex_pkg::reg_addr_t  fwd_mem_addr_i,
    input  ex_pkg::xword_t     fwd_mem_data_i,
    input  logic               fwd_wb_en_i,
    input  ex_pkg::reg_addr_t  fwd_wb_addr_i,
    input  ex_pkg::xword_t     fwd_wb_data_i,
    output logic               valid_o,
    output logic               rd_we_o,
    output logic               jump_o,
    output ex_pkg::xword_t     jump_addr_o,
    output ex_pkg::xword_t     result_o,
    output ex_pkg::xword_t     store_data_o,
    output ex_pkg::reg_addr_t  rd_o,
    output ex_pkg::ex_op_t     op_o,
    output ex_pkg::funct_t     funct_o,
    output logic               ready_o
);

    opnd_if      opnd ();
    exec_out_if  res ();

    operand_forward u_operand_forward (
        .rs1_addr_i     (rs1_addr_i),     .rs2_addr_i     (rs2_addr_i),
        .rs1_data_i     (rs1_data_i),     .rs2_data_i     (rs2_data_i),
        .imm_i          (imm_i),          .pc_i           (pc_i),
        .op_i           (op_i),           .funct_i        (funct_i),
        .word_i         (word_i),
        .fwd_alu_en_i   (fwd_alu_en_i),   .fwd_alu_addr_i (fwd_alu_addr_i),
        .fwd_alu_data_i (fwd_alu_data_i),
        .fwd_ld_en_i    (fwd_ld_en_i),    .fwd_ld_addr_i  (fwd_ld_addr_i),
        .fwd_ld_data_i  (fwd_ld_data_i),
        .fwd_mem_en_i   (fwd_mem_en_i),   .fwd_mem_addr_i (fwd_mem_addr_i),
        .fwd_mem_data_i (fwd_mem_data_i),
        .fwd_wb_en_i    (fwd_wb_en_i),    .fwd_wb_addr_i  (fwd_wb_addr_i),
        .fwd_wb_data_i  (fwd_wb_data_i),
        .opnd           (opnd.source)
    );

    int_alu u_int_alu (
        .opnd (opnd.sink),
        .res  (res.alu_source)
    );

    branch_unit u_branch_unit (
        .opnd (opnd.sink),
        .res  (res.branch_source)
    );

    ex_retire u_ex_retire (
        .clk_sys_i    (clk_sys_i),    .rst_sys_i    (rst_sys_i),
        .valid_i      (valid_i),      .stall_i      (stall_i),
        .opnd         (opnd.sink),    .res          (res.sink),
        .rd_i         (rd_i),
        .valid_o      (valid_o),      .rd_we_o      (rd_we_o),
        .jump_o       (jump_o),       .jump_addr_o  (jump_addr_o),
        .result_o     (result_o),     .store_data_o (store_data_o),
        .rd_o         (rd_o),         .op_o         (op_o),
        .funct_o      (funct_o),      .ready_o      (ready_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_ex_model.svh */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

logic [31:0] lfsr_state = 32'hf6f3_815a;

// Galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[62:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
endfunction

function automatic ex_pkg::xword_t sext32(input ex_pkg::xword_t v);
    return {{32{v[31]}}, v[31:0]};
endfunction

function automatic ex_pkg::xword_t prep(input ex_pkg::xword_t v, input logic word);
    return word ? sext32(v) : v;
endfunction

// alu, ld, mem, wb in that priority, x0 always zero
function automatic ex_pkg::xword_t forward_model(input ex_pkg::reg_addr_t addr,
                                                 input ex_pkg::xword_t rf);
    ex_pkg::xword_t v;
    if (addr == 5'd0) v = '0;
    else if (fwd_alu_en_i && fwd_alu_addr_i == addr) v = fwd_alu_data_i;
    else if (fwd_ld_en_i && fwd_ld_addr_i == addr) v = fwd_ld_data_i;
    else if (fwd_mem_en_i && fwd_mem_addr_i == addr) v = fwd_mem_data_i;
    else if (fwd_wb_en_i && fwd_wb_addr_i == addr) v = fwd_wb_data_i;
    else v = rf;
    return v;
endfunction

function automatic ex_pkg::xword_t alu_model(input ex_pkg::ex_op_t op, input ex_pkg::funct_t fn,
                                             input logic word, input ex_pkg::xword_t a,
                                             input ex_pkg::xword_t b, input ex_pkg::xword_t pc);
    logic           arith;
    logic [5:0]     sh;
    logic [31:0]    lo;
    ex_pkg::xword_t r;
    arith = (op == ex_pkg::op_reg_alt) || (op == ex_pkg::op_imm_sra);
    sh    = word ? {1'b0, b[4:0]} : b[5:0];
    case (fn)
        ex_pkg::fn_add:  r = (op == ex_pkg::op_reg_alt) ? a - b : a + b;
        ex_pkg::fn_sll:  r = a << sh;
        ex_pkg::fn_slt:  r = {63'd0, $signed(a) < $signed(b)};
        ex_pkg::fn_sltu: r = {63'd0, a < b};
        ex_pkg::fn_xor:  r = a ^ b;
        ex_pkg::fn_srl: begin
            if (word) begin
                if (arith) lo = $signed(a[31:0]) >>> sh;
                else lo = a[31:0] >> sh;       // low word only, zero filled
                r = {32'd0, lo};
            end else begin
                if (arith) r = $signed(a) >>> sh;
                else r = a >> sh;
            end
        end
        ex_pkg::fn_or:   r = a | b;
        default:         r = a & b;
    endcase
    if (word && (fn == ex_pkg::fn_add || fn == ex_pkg::fn_sll || fn == ex_pkg::fn_srl)) begin
        r = sext32(r);
    end
    case (op)
        ex_pkg::op_lui:                    r = b;
        ex_pkg::op_auipc:                  r = pc + b;
        ex_pkg::op_load, ex_pkg::op_store: r = a + b;   // address
        default: ;
    endcase
    return r;
endfunction

function automatic logic branch_taken(input ex_pkg::ex_op_t op, input ex_pkg::funct_t fn,
                                      input ex_pkg::xword_t a, input ex_pkg::xword_t b);
    logic t;
    case (fn)
        ex_pkg::fn_beq:  t = (a == b);
        ex_pkg::fn_bne:  t = (a != b);
        ex_pkg::fn_blt:  t = ($signed(a) < $signed(b));
        ex_pkg::fn_bge:  t = ($signed(a) >= $signed(b));
        ex_pkg::fn_bltu: t = (a < b);
        ex_pkg::fn_bgeu: t = (a >= b);
        default:         t = 1'b0;
    endcase
    if (op == ex_pkg::op_jal || op == ex_pkg::op_jalr) t = 1'b1;
    else if (op != ex_pkg::op_branch) t = 1'b0;
    return t;
endfunction

function automatic logic writes_rd(input ex_pkg::ex_op_t op);
    return op inside {ex_pkg::op_reg, ex_pkg::op_reg_alt, ex_pkg::op_imm, ex_pkg::op_imm_sra,
                      ex_pkg::op_lui, ex_pkg::op_auipc, ex_pkg::op_jal, ex_pkg::op_jalr};
endfunction

`endif

/* testbench/tb_ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;

    logic               clk_sys_i;
    logic               rst_sys_i;
    logic               valid_i;
    logic               stall_i;
    logic               word_i;
    logic               fwd_alu_en_i, fwd_ld_en_i, fwd_mem_en_i, fwd_wb_en_i;
    ex_pkg::reg_addr_t  rd_i, rs1_addr_i, rs2_addr_i;
    ex_pkg::reg_addr_t  fwd_alu_addr_i, fwd_ld_addr_i, fwd_mem_addr_i, fwd_wb_addr_i;
    ex_pkg::xword_t     rs1_data_i, rs2_data_i, imm_i, pc_i;
    ex_pkg::xword_t     fwd_alu_data_i, fwd_ld_data_i, fwd_mem_data_i, fwd_wb_data_i;
    ex_pkg::ex_op_t     op_i;
    ex_pkg::funct_t     funct_i;
    logic               valid_o, rd_we_o, jump_o, ready_o;
    ex_pkg::xword_t     jump_addr_o, result_o, store_data_o;
    ex_pkg::reg_addr_t  rd_o;
    ex_pkg::ex_op_t     op_o;
    ex_pkg::funct_t     funct_o;

    ex_pkg::xword_t     exp_result, exp_store, exp_target;
    ex_pkg::reg_addr_t  exp_rd;
    ex_pkg::ex_op_t     exp_op;
    ex_pkg::funct_t     exp_fn;
    logic               exp_take, exp_we, exp_has_result;
    int                 errors = 0;
    int                 checks = 0;
    int                 mark_errors = 0;
    int                 mark_checks = 0;

    `include "tb_ex_model.svh"

    ex_stage dut_i (.*);

    initial begin
        clk_sys_i = 1'b0;
        forever #10 clk_sys_i = ~clk_sys_i;
    end

    task automatic check_value(input string name, input ex_pkg::xword_t got,
                               input ex_pkg::xword_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-8s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic report_and_finish();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic present_random(input ex_pkg::ex_op_t op, input ex_pkg::funct_t fn,
                                  input logic word);
        op_i       = op;
        funct_i    = fn;
        word_i     = word;
        {rd_i, rs1_addr_i, rs2_addr_i} = 15'(rand_bits(15));
        rs1_data_i = rand_bits(64);
        rs2_data_i = rand_bits(64);
        imm_i      = rand_bits(64);
        pc_i       = rand_bits(64);
        {fwd_alu_en_i, fwd_ld_en_i, fwd_mem_en_i, fwd_wb_en_i} = 4'b0000;
        {fwd_alu_addr_i, fwd_ld_addr_i, fwd_mem_addr_i, fwd_wb_addr_i} = 20'(rand_bits(20));
        valid_i    = 1'b1;
    endtask

    task automatic compute_expected();
        ex_pkg::xword_t a, b, im;
        a  = prep(forward_model(rs1_addr_i, rs1_data_i), word_i);
        b  = prep(forward_model(rs2_addr_i, rs2_data_i), word_i);
        im = prep(imm_i, word_i);
        exp_take       = branch_taken(op_i, funct_i, a, b);
        exp_target     = ((op_i == ex_pkg::op_jalr) ? a : pc_i) + im;
        exp_we         = writes_rd(op_i);
        exp_store      = b;
        exp_rd         = rd_i;
        exp_op         = op_i;
        exp_fn         = funct_i;
        exp_has_result = (op_i != ex_pkg::op_branch);
        if (op_i == ex_pkg::op_jal || op_i == ex_pkg::op_jalr) begin
            exp_result = pc_i + ex_pkg::link_offset;
        end else if (op_i == ex_pkg::op_reg || op_i == ex_pkg::op_reg_alt) begin
            exp_result = alu_model(op_i, funct_i, word_i, a, b, pc_i);
        end else begin
            exp_result = alu_model(op_i, funct_i, word_i, a, im, pc_i);
        end
    endtask

    task automatic clock_in();
        @(posedge clk_sys_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic check_outputs();
        check_bit("valid_o", valid_o, 1'b1);
        check_bit("jump_o", jump_o, exp_take);
        check_bit("rd_we_o", rd_we_o, exp_we);
        check_value("rd_o", ex_pkg::xword_t'(rd_o), ex_pkg::xword_t'(exp_rd));
        check_value("op_o", ex_pkg::xword_t'(op_o), ex_pkg::xword_t'(exp_op));
        check_value("funct_o", ex_pkg::xword_t'(funct_o), ex_pkg::xword_t'(exp_fn));
        check_value("store_data_o", store_data_o, exp_store);
        if (exp_has_result) check_value("result_o", result_o, exp_result);
        if (exp_take) check_value("jump_addr_o", jump_addr_o, exp_target);
    endtask

    // waits for ready_o, then the accepting edge and the result
    task automatic execute();
        int n;
        n = 0;
        #1;
        while (!ready_o && n < 20) begin
            @(posedge clk_sys_i);
            #1;
            n++;
        end
        if (!ready_o) begin
            $display("timeout: stage did not become ready to accept an instruction");
            errors++;
            report_and_finish();
        end else begin
            clock_in();
            check_outputs();
        end
    endtask

    task automatic issue(input ex_pkg::ex_op_t op, input ex_pkg::funct_t fn, input logic word);
        present_random(op, fn, word);
        compute_expected();
        execute();
    endtask

    task automatic run_int_mix(input logic word);
        repeat (3) begin
            for (int f = 0; f < 8; f++) begin
                issue(ex_pkg::op_reg, ex_pkg::funct_t'(f), word);
                issue(ex_pkg::op_imm, ex_pkg::funct_t'(f), word);
            end
            issue(ex_pkg::op_reg_alt, ex_pkg::fn_add, word);    // sub
            issue(ex_pkg::op_reg_alt, ex_pkg::fn_srl, word);    // sra
            issue(ex_pkg::op_imm_sra, ex_pkg::fn_srl, word);
            issue(ex_pkg::op_lui, ex_pkg::fn_add, word);
            issue(ex_pkg::op_auipc, ex_pkg::fn_add, word);
            issue(ex_pkg::op_load, ex_pkg::fn_add, word);
            issue(ex_pkg::op_store, ex_pkg::fn_add, word);
        end
    endtask

    initial begin
        ex_pkg::reg_addr_t  r;
        ex_pkg::xword_t     hold_result;
        ex_pkg::reg_addr_t  hold_rd;
        rst_sys_i = 1'b1;
        stall_i   = 1'b0;
        present_random(ex_pkg::op_reg, ex_pkg::fn_add, 1'b0);
        valid_i   = 1'b0;
        {fwd_alu_data_i, fwd_ld_data_i, fwd_mem_data_i, fwd_wb_data_i} = '0;
        repeat (3) @(posedge clk_sys_i);
        #1;
        rst_sys_i = 1'b0;
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("jump_o", jump_o, 1'b0);
        check_bit("rd_we_o", rd_we_o, 1'b0);
        check_bit("ready_o", ready_o, 1'b1);
        end_test("reset");

        run_int_mix(1'b0);
        end_test("integer");
        run_int_mix(1'b1);
        end_test("word");

        // k drops sources from the top of the priority list, k == 4 targets x0
        for (int k = 0; k < 5; k++) begin
            present_random(ex_pkg::op_reg, ex_pkg::fn_add, 1'b0);
            r = (k == 4) ? 5'd0 : (ex_pkg::reg_addr_t'(rand_bits(5)) | 5'd1);
            rs1_addr_i = r;
            rs2_addr_i = r;
            {fwd_alu_addr_i, fwd_ld_addr_i, fwd_mem_addr_i, fwd_wb_addr_i} = {4{r}};
            {fwd_alu_en_i, fwd_ld_en_i, fwd_mem_en_i, fwd_wb_en_i} =
                (k == 4) ? 4'b1111 : (4'b1111 >> k);
            fwd_alu_data_i = rand_bits(64);
            fwd_ld_data_i  = rand_bits(64);
            fwd_mem_data_i = rand_bits(64);
            fwd_wb_data_i  = rand_bits(64);
            compute_expected();
            execute();
        end
        end_test("forward");

        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                repeat (6) begin
                    present_random(ex_pkg::op_branch, ex_pkg::funct_t'(f), 1'b0);
                    if (rand_bits(1) == 64'd1) begin      // equal pair
                        rs2_addr_i = rs1_addr_i;
                        rs2_data_i = rs1_data_i;
                    end
                    compute_expected();
                    execute();
                end
            end
        end
        issue(ex_pkg::op_jalr, ex_pkg::fn_add, 1'b0);
        issue(ex_pkg::op_jal, ex_pkg::fn_add, 1'b0);
        present_random(ex_pkg::op_imm, ex_pkg::fn_add, 1'b0);
        compute_expected();
        repeat (2) begin                                  // flush shadow
            @(posedge clk_sys_i);
            #1;
            check_bit("valid_o", valid_o, 1'b0);
            check_bit("jump_o", jump_o, 1'b0);
        end
        execute();
        end_test("branch");

        issue(ex_pkg::op_reg, ex_pkg::fn_add, 1'b0);
        hold_result = exp_result;
        hold_rd     = exp_rd;
        present_random(ex_pkg::op_imm, ex_pkg::fn_xor, 1'b0);
        stall_i = 1'b1;
        compute_expected();
        repeat (3) begin
            @(posedge clk_sys_i);
            #1;
            check_bit("valid_o", valid_o, 1'b1);
            check_bit("ready_o", ready_o, 1'b0);
            check_value("result_o", result_o, hold_result);
            check_value("rd_o", ex_pkg::xword_t'(rd_o), ex_pkg::xword_t'(hold_rd));
        end
        stall_i = 1'b0;
        clock_in();
        check_outputs();
        end_test("stall");

        report_and_finish();
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
verilog/ex_pkg.sv
verilog/opnd_if.sv
verilog/exec_out_if.sv
verilog/operand_forward.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/ex_retire.sv
verilog/ex_stage.sv
testbench/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_ex_stage -f compile.f -o tb_ex_stage \
    && ./obj_dir/tb_ex_stage | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
